// ==== source/fpdiv_fmt_pkg.sv ====
package fpdiv_fmt_pkg;

	// ========================================
	// floating-point format encoding
	// ========================================

	// format code as seen on the start interface
	typedef enum logic [1:0] {
		FMT_FP16 = 2'd0,
		FMT_FP32 = 2'd1,
		FMT_FP64 = 2'd2
	} fp_format_e;

	// input significand width, widest format
	localparam int FRAC_W = 53;
	// quotient width presented at the output
	localparam int QUO_OUT_W = 55;

	// significand widths with the hidden bit
	localparam int FP16_FRAC_W = 11;
	localparam int FP32_FRAC_W = 24;
	localparam int FP64_FRAC_W = 53;

	// ========================================
	// iteration counts
	// ========================================

	// counter width, enough for the fp64 count
	localparam int ITER_CNT_W = 4;
	// initial counter values, one below the number of iteration cycles
	// each cycle retires three radix-4 digits
	localparam logic [ITER_CNT_W-1:0] ITER_CNT_FP16 = 4'd1;
	localparam logic [ITER_CNT_W-1:0] ITER_CNT_FP32 = 4'd3;
	localparam logic [ITER_CNT_W-1:0] ITER_CNT_FP64 = 4'd8;

	// significand word, field sits in the low bits
	typedef logic [FRAC_W-1:0] frac_t;

endpackage

// ==== source/srt_pkg.sv ====
package srt_pkg;

	// ========================================
	// recurrence widths
	// ========================================

	// sign + 2 integer bits + 53 frac bits + 3 scaling bits + 1 lsb
	// unit weight of the remainder sits at bit 57
	localparam int REM_W = 60;
	// 53-bit operand times the 5-bit scaling factor
	localparam int SCALED_W = 58;
	// 28 radix-4 digits for fp64
	localparam int QUO_W = 56;
	// remainder estimate bits read by digit selection
	localparam int QDS_REM_W = 6;
	// radix-4 steps chained in one clock
	localparam int STAGES_PER_CYCLE = 3;

	// ========================================
	// quotient digits
	// ========================================

	// one-hot digit, -2 at the top and +2 at the bottom
	typedef logic [4:0] quo_dig_t;
	localparam int DIG_NEG2 = 4;
	localparam int DIG_NEG1 = 3;
	localparam int DIG_ZERO = 2;
	localparam int DIG_POS1 = 1;
	localparam int DIG_POS2 = 0;

	// partial remainder in carry-save form
	typedef struct packed {
		logic [REM_W-1:0] sum;
		logic [REM_W-1:0] carry;
	} rem_cs_t;

	// signed-digit quotient as two plain vectors
	typedef struct packed {
		logic [QUO_W-1:0] pos;
		logic [QUO_W-1:0] neg;
	} quo_pair_t;

	// divisor multiples ready for the 3:2 adder
	// negative ones are inverted, the +1 enters as carry-in
	typedef struct packed {
		logic [REM_W-1:0] pos_2;
		logic [REM_W-1:0] pos_1;
		logic [REM_W-1:0] neg_1;
		logic [REM_W-1:0] neg_2;
	} divisor_mults_t;

	// one-hot controller state
	typedef enum logic [4:0] {
		ST_IDLE  = 5'b00001,
		ST_SETUP = 5'b00010,
		ST_ITER  = 5'b00100,
		ST_POST  = 5'b01000,
		ST_DONE  = 5'b10000
	} ctrl_state_e;

endpackage

// ==== source/srt_ctrl.sv ====
`timescale 1ns/1ps

module srt_ctrl
	import fpdiv_fmt_pkg::*;
	import srt_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        start_valid_i,
	input  logic        finish_ready_i,
	input  logic        flush_i,
	input  fp_format_e  fp_format_i,
	output ctrl_state_e state_o,
	output logic        start_ready_o,
	output logic        finish_valid_o
);

	ctrl_state_e           state_d;
	ctrl_state_e           state_q;
	logic [ITER_CNT_W-1:0] iter_cnt_init;
	logic [ITER_CNT_W-1:0] iter_cnt_q;
	logic                  last_iter;

	// ========================================
	// iteration counter
	// ========================================

	always_comb begin
		case (fp_format_i)
			FMT_FP16: iter_cnt_init = ITER_CNT_FP16;
			FMT_FP32: iter_cnt_init = ITER_CNT_FP32;
			default:  iter_cnt_init = ITER_CNT_FP64;
		endcase
	end

	// reloaded every idle cycle, the handshake cycle wins
	always_ff @(posedge clk) begin
		if (state_q == ST_IDLE) begin
			iter_cnt_q <= iter_cnt_init;
		end else if (state_q == ST_ITER) begin
			iter_cnt_q <= iter_cnt_q - 1'b1;
		end
	end

	assign last_iter = (iter_cnt_q == '0);

	// ========================================
	// state machine
	// ========================================

	always_comb begin
		unique case (state_q)
			ST_IDLE:  state_d = start_valid_i ? ST_SETUP : ST_IDLE;
			ST_SETUP: state_d = ST_ITER;
			ST_ITER:  state_d = last_iter ? ST_POST : ST_ITER;
			ST_POST:  state_d = ST_DONE;
			ST_DONE:  state_d = finish_ready_i ? ST_IDLE : ST_DONE;
			default:  state_d = ST_IDLE;
		endcase
		// flush beats any handshake
		if (flush_i) begin
			state_d = ST_IDLE;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// handshakes decoded straight from the one-hot state
	assign start_ready_o  = (state_q == ST_IDLE);
	assign finish_valid_o = (state_q == ST_DONE);
	assign state_o        = state_q;

endmodule

// ==== source/srt_prescale.sv ====
`timescale 1ns/1ps

module srt_prescale
	import fpdiv_fmt_pkg::*;
	import srt_pkg::*;
(
	input  fp_format_e          fp_format_i,
	input  frac_t               a_frac_i,
	input  frac_t               b_frac_i,
	output rem_cs_t             init_rem_o,
	output quo_pair_t           init_quo_o,
	output logic [SCALED_W-1:0] scaled_div_o
);

	// 1.5 in units of 1/8, the +1/+2 boundary for the first digit
	localparam logic [4:0] FIRST_POS2_MIN = 5'd12;

	frac_t               a_align;
	frac_t               b_align;
	logic [2:0]          factor_sel;
	logic [4:0]          factor;
	logic [SCALED_W-1:0] scaled_a;
	logic [SCALED_W-1:0] scaled_b;
	logic                a_lt_b;
	logic [SCALED_W:0]   dividend;
	logic [REM_W-1:0]    div_ext;
	logic                first_pos_2;

	// ========================================
	// alignment
	// ========================================

	// field moved to the top of 53 bits, junk above the field dropped
	always_comb begin
		case (fp_format_i)
			FMT_FP16: begin
				a_align = {a_frac_i[FP16_FRAC_W-1:0], {(FRAC_W-FP16_FRAC_W){1'b0}}};
				b_align = {b_frac_i[FP16_FRAC_W-1:0], {(FRAC_W-FP16_FRAC_W){1'b0}}};
			end
			FMT_FP32: begin
				a_align = {a_frac_i[FP32_FRAC_W-1:0], {(FRAC_W-FP32_FRAC_W){1'b0}}};
				b_align = {b_frac_i[FP32_FRAC_W-1:0], {(FRAC_W-FP32_FRAC_W){1'b0}}};
			end
			default: begin
				a_align = a_frac_i[FP64_FRAC_W-1:0];
				b_align = b_frac_i[FP64_FRAC_W-1:0];
			end
		endcase
	end

	// ========================================
	// scaling
	// ========================================

	// three divisor bits below the hidden bit
	assign factor_sel = b_align[FRAC_W-2 -: 3];

	// factor/16 brings the divisor into roughly [63/64, 9/8)
	always_comb begin
		case (factor_sel)
			3'd0:    factor = 5'd16;
			3'd1:    factor = 5'd14;
			3'd2:    factor = 5'd13;
			3'd3:    factor = 5'd12;
			3'd4:    factor = 5'd11;
			3'd5:    factor = 5'd10;
			default: factor = 5'd9;
		endcase
	end

	assign scaled_a = a_align * factor;
	assign scaled_b = b_align * factor;
	assign a_lt_b   = (scaled_a < scaled_b);

	// dividend doubled when below the divisor, so the quotient lands in [1, 2)
	assign dividend = a_lt_b ? {scaled_a, 1'b0} : {1'b0, scaled_a};

	// ========================================
	// first digit and initial remainder
	// ========================================

	// unit weight at bit 57, low bit carries the +1 of the negation
	assign init_rem_o.sum = {dividend, 1'b1};

	// exact dividend, so 5 bits are enough for the compare
	assign first_pos_2 = (init_rem_o.sum[REM_W-2 -: 5] >= FIRST_POS2_MIN);

	// subtract 2D or 1D through the inverted multiple
	assign div_ext          = {1'b0, scaled_b, 1'b0};
	assign init_rem_o.carry = first_pos_2 ? ~{div_ext[REM_W-2:0], 1'b0} : ~div_ext;

	// integer digit as 2'b10 or 2'b01
	assign init_quo_o.pos = {{(QUO_W-2){1'b0}}, first_pos_2, ~first_pos_2};
	assign init_quo_o.neg = '0;

	assign scaled_div_o = scaled_b;

endmodule

// ==== source/srt_r4_qds.sv ====
`timescale 1ns/1ps

module srt_r4_qds
	import srt_pkg::*;
(
	input  logic [QDS_REM_W-1:0] rem_top_i,
	output quo_dig_t             quo_dig_o
);

	// thresholds on 4*w in units of 1/8
	// hold for the scaled divisor range with a truncated carry-save estimate
	localparam logic signed [QDS_REM_W-1:0] M_POS2 = 6'sd12;
	localparam logic signed [QDS_REM_W-1:0] M_POS1 = 6'sd4;
	localparam logic signed [QDS_REM_W-1:0] M_ZERO = -6'sd4;
	localparam logic signed [QDS_REM_W-1:0] M_NEG1 = -6'sd13;

	logic signed [QDS_REM_W-1:0] rem_est;

	// two's complement, weights -4 down to 1/8
	assign rem_est = rem_top_i;

	always_comb begin
		quo_dig_o = '0;
		if (rem_est >= M_POS2) begin
			quo_dig_o[DIG_POS2] = 1'b1;
		end else if (rem_est >= M_POS1) begin
			quo_dig_o[DIG_POS1] = 1'b1;
		end else if (rem_est >= M_ZERO) begin
			quo_dig_o[DIG_ZERO] = 1'b1;
		end else if (rem_est >= M_NEG1) begin
			quo_dig_o[DIG_NEG1] = 1'b1;
		end else begin
			// deepest negative region
			quo_dig_o[DIG_NEG2] = 1'b1;
		end
	end

endmodule

// ==== source/srt_r4_stage.sv ====
`timescale 1ns/1ps

module srt_r4_stage
	import srt_pkg::*;
(
	input  rem_cs_t        rem_i,
	input  quo_pair_t      quo_i,
	input  divisor_mults_t mults_i,
	output rem_cs_t        rem_o,
	output quo_pair_t      quo_o
);

	logic [QDS_REM_W-1:0] rem_top;
	quo_dig_t             quo_dig;
	logic [REM_W-1:0]     sum_sh;
	logic [REM_W-1:0]     carry_sh;
	logic [REM_W-1:0]     mult_sel;
	logic                 mult_neg;
	logic [REM_W-1:0]     maj;

	// ========================================
	// digit selection
	// ========================================

	// top of w becomes the top of 4*w after the shift
	// short carry-propagate add, wraps in 6 bits
	assign rem_top = rem_i.sum[REM_W-3 -: QDS_REM_W] + rem_i.carry[REM_W-3 -: QDS_REM_W];

	srt_r4_qds u_qds (
		.rem_top_i (rem_top),
		.quo_dig_o (quo_dig)
	);

	// ========================================
	// remainder update
	// ========================================

	assign sum_sh   = {rem_i.sum[REM_W-3:0], 2'b00};
	assign carry_sh = {rem_i.carry[REM_W-3:0], 2'b00};

	// negative digit adds a positive multiple and vice versa
	// zero digit leaves the multiple at zero
	assign mult_sel =
		  ({REM_W{quo_dig[DIG_NEG2]}} & mults_i.pos_2)
		| ({REM_W{quo_dig[DIG_NEG1]}} & mults_i.pos_1)
		| ({REM_W{quo_dig[DIG_POS1]}} & mults_i.neg_1)
		| ({REM_W{quo_dig[DIG_POS2]}} & mults_i.neg_2);

	// completes the two's complement of the inverted multiple
	assign mult_neg = quo_dig[DIG_POS1] | quo_dig[DIG_POS2];

	// 3:2 compression
	assign maj = (sum_sh & carry_sh) | (sum_sh & mult_sel) | (carry_sh & mult_sel);

	assign rem_o.sum   = sum_sh ^ carry_sh ^ mult_sel;
	// carry moves up one, carry-in fills the free lsb
	assign rem_o.carry = {maj[REM_W-2:0], mult_neg};

	// ========================================
	// quotient append
	// ========================================

	// +2 and -2 go to the upper bit of the pair
	assign quo_o.pos = {quo_i.pos[QUO_W-3:0], quo_dig[DIG_POS2], quo_dig[DIG_POS1]};
	assign quo_o.neg = {quo_i.neg[QUO_W-3:0], quo_dig[DIG_NEG2], quo_dig[DIG_NEG1]};

endmodule

// ==== source/srt_iter_core.sv ====
`timescale 1ns/1ps

module srt_iter_core
	import srt_pkg::*;
(
	input  logic                clk,
	input  ctrl_state_e         state_i,
	input  rem_cs_t             init_rem_i,
	input  quo_pair_t           init_quo_i,
	input  logic [SCALED_W-1:0] scaled_div_i,
	output rem_cs_t             rem_o,
	output quo_pair_t           quo_o,
	output logic [REM_W-1:0]    divisor_o
);

	rem_cs_t             rem_q;
	quo_pair_t           quo_q;
	logic [SCALED_W-1:0] div_q;
	logic [REM_W-1:0]    div_ext;
	divisor_mults_t      mults;
	rem_cs_t             rem_chain [STAGES_PER_CYCLE+1];
	quo_pair_t           quo_chain [STAGES_PER_CYCLE+1];

	// ========================================
	// iteration registers
	// ========================================

	// idle keeps sampling the prescaler
	// iter takes three digits per clock
	// setup, post and done hold
	always_ff @(posedge clk) begin
		if (state_i == ST_IDLE) begin
			rem_q <= init_rem_i;
			quo_q <= init_quo_i;
			div_q <= scaled_div_i;
		end else if (state_i == ST_ITER) begin
			rem_q <= rem_chain[STAGES_PER_CYCLE];
			quo_q <= quo_chain[STAGES_PER_CYCLE];
		end
	end

	// divisor aligned to the remainder, unit at bit 57
	assign div_ext = {1'b0, div_q, 1'b0};

	// multiples built once, shared by every stage
	assign mults.pos_1 = div_ext;
	assign mults.pos_2 = {div_ext[REM_W-2:0], 1'b0};
	assign mults.neg_1 = ~mults.pos_1;
	assign mults.neg_2 = ~mults.pos_2;

	// ========================================
	// chained radix-4 stages
	// ========================================

	assign rem_chain[0] = rem_q;
	assign quo_chain[0] = quo_q;

	for (genvar i = 0; i < STAGES_PER_CYCLE; i++) begin : g_stage
		srt_r4_stage u_stage (
			.rem_i   (rem_chain[i]),
			.quo_i   (quo_chain[i]),
			.mults_i (mults),
			.rem_o   (rem_chain[i+1]),
			.quo_o   (quo_chain[i+1])
		);
	end

	assign rem_o     = rem_q;
	assign quo_o     = quo_q;
	assign divisor_o = div_ext;

endmodule

// ==== source/srt_post.sv ====
`timescale 1ns/1ps

module srt_post
	import fpdiv_fmt_pkg::*;
	import srt_pkg::*;
(
	input  rem_cs_t                rem_i,
	input  quo_pair_t              quo_i,
	output logic [QUO_OUT_W-1:0]   quo_o
);

	logic [REM_W-1:0] rem_nr;
	logic             rem_neg;
	logic [QUO_W-1:0] quo_nr;

	// full add only for the sign of the last remainder
	assign rem_nr  = rem_i.sum + rem_i.carry;
	assign rem_neg = rem_nr[REM_W-1];

	// negative remainder means the digits overshot by one ulp
	assign quo_nr = quo_i.pos - quo_i.neg - {{(QUO_W-1){1'b0}}, rem_neg};

	// top bit is always clear once corrected
	assign quo_o = quo_nr[QUO_OUT_W-1:0];

endmodule

// ==== source/fpdiv_frac.sv ====
`timescale 1ns/1ps

module fpdiv_frac
	import fpdiv_fmt_pkg::*;
	import srt_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start_valid_i,
	output logic                 start_ready_o,
	input  logic                 flush_i,
	input  fp_format_e           fp_format_i,
	input  frac_t                a_frac_i,
	input  frac_t                b_frac_i,
	output logic                 finish_valid_o,
	input  logic                 finish_ready_i,
	output logic [QUO_OUT_W-1:0] fpdiv_frac_o
);

	ctrl_state_e         state;
	rem_cs_t             init_rem;
	quo_pair_t           init_quo;
	logic [SCALED_W-1:0] scaled_div;
	rem_cs_t             rem;
	quo_pair_t           quo;

	// ========================================
	// control
	// ========================================

	srt_ctrl u_ctrl (
		.clk            (clk),
		.rst_n          (rst_n),
		.start_valid_i  (start_valid_i),
		.finish_ready_i (finish_ready_i),
		.flush_i        (flush_i),
		.fp_format_i    (fp_format_i),
		.state_o        (state),
		.start_ready_o  (start_ready_o),
		.finish_valid_o (finish_valid_o)
	);

	// ========================================
	// datapath
	// ========================================

	// purely combinational from the start inputs
	srt_prescale u_prescale (
		.fp_format_i  (fp_format_i),
		.a_frac_i     (a_frac_i),
		.b_frac_i     (b_frac_i),
		.init_rem_o   (init_rem),
		.init_quo_o   (init_quo),
		.scaled_div_o (scaled_div)
	);

	// extended divisor only serves a remainder fix-up
	// the fraction result needs just the remainder sign
	srt_iter_core u_core (
		.clk          (clk),
		.state_i      (state),
		.init_rem_i   (init_rem),
		.init_quo_i   (init_quo),
		.scaled_div_i (scaled_div),
		.rem_o        (rem),
		.quo_o        (quo),
		.divisor_o    ()
	);

	// result held by the core registers while done waits for ready
	srt_post u_post (
		.rem_i (rem),
		.quo_i (quo),
		.quo_o (fpdiv_frac_o)
	);

endmodule

// ==== tests/tb_fpdiv_model.svh ====
`ifndef TB_FPDIV_MODEL_SVH
`define TB_FPDIV_MODEL_SVH

// ========================================
// random source
// ========================================

// xorshift32 state, seeded by the testbench top
logic [31:0] rng_state;

function automatic logic [31:0] next_random();
	rng_state = rng_state ^ (rng_state << 13);
	rng_state = rng_state ^ (rng_state >> 17);
	rng_state = rng_state ^ (rng_state << 5);
	return rng_state;
endfunction

// significand width with the hidden bit
function automatic int field_width(input fp_format_e fmt);
	case (fmt)
		FMT_FP16: return 11;
		FMT_FP32: return 24;
		default:  return 53;
	endcase
endfunction

// hidden bit set, junk left above the field
function automatic frac_t random_operand(input fp_format_e fmt);
	logic [63:0] raw;
	frac_t       op;
	int          fw;
	fw = field_width(fmt);
	raw = {next_random(), next_random()};
	op = raw[FRAC_W-1:0];
	op[fw-1] = 1'b1;
	return op;
endfunction

// ========================================
// reference quotient
// ========================================

// floor(a' * 2^m / b), a' doubled when a < b
function automatic logic [QUO_OUT_W-1:0] model_quotient(input fp_format_e fmt,
		input frac_t a_in, input frac_t b_in);
	logic [127:0] a_f;
	logic [127:0] b_f;
	logic [127:0] mask;
	logic [127:0] quo;
	int           m;
	case (fmt)
		FMT_FP16: m = 12;
		FMT_FP32: m = 24;
		default:  m = 54;
	endcase
	mask = (128'd1 << field_width(fmt)) - 128'd1;
	a_f = {75'd0, a_in} & mask;
	b_f = {75'd0, b_in} & mask;
	if (a_f < b_f) begin
		a_f = a_f << 1;
	end
	quo = (a_f << m) / b_f;
	return quo[QUO_OUT_W-1:0];
endfunction

// single compare point for every value check
task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] expected);
	if (got !== expected) begin
		error_count++;
		$display("Error at %0t: %s is %h, expected %h", $time, name, got, expected);
	end
endtask

`endif

// ==== tests/tb_fpdiv_frac.sv ====
`timescale 1ns/1ps

module tb_fpdiv_frac
	import fpdiv_fmt_pkg::*;
();

	localparam logic [31:0] SEED = 32'hc4545e40;
	// loop bounds for every wait
	localparam int LATENCY_LIMIT = 40;
	localparam int READY_LIMIT   = 40;

	logic                 clk;
	logic                 rst_n;
	logic                 start_valid_i;
	logic                 start_ready_o;
	logic                 flush_i;
	fp_format_e           fp_format_i;
	frac_t                a_frac_i;
	frac_t                b_frac_i;
	logic                 finish_valid_o;
	logic                 finish_ready_i;
	logic [QUO_OUT_W-1:0] fpdiv_frac_o;
	int                   error_count;
	int                   timeout_count;

	`include "tb_fpdiv_model.svh"

	fpdiv_frac u_fpdiv_frac (
		.clk            (clk),
		.rst_n          (rst_n),
		.start_valid_i  (start_valid_i),
		.start_ready_o  (start_ready_o),
		.flush_i        (flush_i),
		.fp_format_i    (fp_format_i),
		.a_frac_i       (a_frac_i),
		.b_frac_i       (b_frac_i),
		.finish_valid_o (finish_valid_o),
		.finish_ready_i (finish_ready_i),
		.fpdiv_frac_o   (fpdiv_frac_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ========================================
	// helpers
	// ========================================

	// edges from start handshake to finish_valid_o
	function automatic int finish_latency(input fp_format_e fmt);
		case (fmt)
			FMT_FP16: return 4;
			FMT_FP32: return 6;
			default:  return 11;
		endcase
	endfunction

	function automatic fp_format_e random_format();
		case (next_random() % 3)
			0:       return FMT_FP16;
			1:       return FMT_FP32;
			default: return FMT_FP64;
		endcase
	endfunction

	// returns on a falling edge with the DUT idle
	task automatic wait_start_ready();
		int waits;
		waits = 0;
		@(negedge clk);
		while (!start_ready_o && waits < LATENCY_LIMIT) begin
			@(negedge clk);
			waits++;
		end
		if (!start_ready_o) begin
			timeout_count++;
			$display("Timeout: start_ready_o stayed low at %0t", $time);
		end
	endtask

	// start handshake and then step past the handshake edge
	task automatic start_division(input fp_format_e fmt, input frac_t a, input frac_t b);
		wait_start_ready();
		fp_format_i    = fmt;
		a_frac_i       = a;
		b_frac_i       = b;
		start_valid_i  = 1'b1;
		finish_ready_i = 1'b0;
		@(posedge clk);
		@(negedge clk);
		start_valid_i = 1'b0;
		// operands already captured so scramble them
		a_frac_i = random_operand(fmt);
		b_frac_i = random_operand(fmt);
	endtask

	// ========================================
	// one division with latency and result checks
	// ========================================

	task automatic run_division(input fp_format_e fmt, input frac_t a, input frac_t b,
			input bit backpressure);
		logic [QUO_OUT_W-1:0] expected;
		logic [QUO_OUT_W-1:0] held;
		int                   edges;
		int                   waits;
		bit                   ready;
		expected = model_quotient(fmt, a, b);
		start_division(fmt, a, b);
		edges = 0;
		while (!finish_valid_o && edges < LATENCY_LIMIT) begin
			check_value("start_ready_o", start_ready_o, 1'b0);
			@(posedge clk);
			edges++;
			@(negedge clk);
		end
		if (!finish_valid_o) begin
			timeout_count++;
			$display("Timeout: finish_valid_o never rose, format code %0d", fmt);
		end else begin
			check_value("finish latency", edges, finish_latency(fmt));
			check_value("fpdiv_frac_o", fpdiv_frac_o, expected);
			held  = fpdiv_frac_o;
			waits = 0;
			// ready toggles at random and is forced high after a while
			while (finish_valid_o && waits < READY_LIMIT) begin
				ready = !backpressure || ((next_random() & 1) != 0) || (waits >= 16);
				finish_ready_i = ready;
				@(posedge clk);
				@(negedge clk);
				waits++;
				if (!ready) begin
					check_value("fpdiv_frac_o held", fpdiv_frac_o, held);
					check_value("finish_valid_o", finish_valid_o, 1'b1);
					check_value("start_ready_o", start_ready_o, 1'b0);
				end
			end
			if (finish_valid_o) begin
				timeout_count++;
				$display("Timeout: finish handshake never completed at %0t", $time);
			end
			// cycle after the finish handshake
			check_value("start_ready_o after finish", start_ready_o, 1'b1);
			check_value("finish_valid_o after finish", finish_valid_o, 1'b0);
			finish_ready_i = 1'b0;
		end
	endtask

	task automatic run_edge_cases(input fp_format_e fmt);
		frac_t min_op;
		frac_t max_op;
		frac_t op;
		int    fw;
		int    sel;
		fw = field_width(fmt);
		min_op = '0;
		min_op[fw-1] = 1'b1;
		max_op = (min_op << 1) - 1'b1;
		op = random_operand(fmt);
		run_division(fmt, op, op, 1'b0);
		run_division(fmt, min_op, max_op, 1'b0);
		run_division(fmt, max_op, min_op, 1'b0);
		// every scaling-factor selector
		for (sel = 0; sel < 8; sel++) begin
			op = random_operand(fmt);
			op[fw-2 -: 3] = sel[2:0];
			run_division(fmt, random_operand(fmt), op, 1'b0);
		end
	endtask

	// flush somewhere in setup, iter or done
	task automatic run_flush(input fp_format_e fmt);
		int delay;
		int count;
		start_division(fmt, random_operand(fmt), random_operand(fmt));
		delay = next_random() % (finish_latency(fmt) + 3);
		for (count = 0; count < delay; count++) begin
			@(posedge clk);
			@(negedge clk);
		end
		flush_i = 1'b1;
		@(posedge clk);
		@(negedge clk);
		flush_i = 1'b0;
		check_value("start_ready_o after flush", start_ready_o, 1'b1);
		check_value("finish_valid_o after flush", finish_valid_o, 1'b0);
	endtask

	// ========================================
	// main sequence
	// ========================================

	initial begin
		int i;
		fp_format_e fmt;
		rng_state      = SEED;
		error_count    = 0;
		timeout_count  = 0;
		rst_n          = 1'b0;
		start_valid_i  = 1'b0;
		flush_i        = 1'b0;
		fp_format_i    = FMT_FP64;
		a_frac_i       = '0;
		b_frac_i       = '0;
		finish_ready_i = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_value("start_ready_o after reset", start_ready_o, 1'b1);
		check_value("finish_valid_o after reset", finish_valid_o, 1'b0);

		// random operands with the formats in turn
		for (i = 0; i < 60; i++) begin
			case (i % 3)
				0:       fmt = FMT_FP64;
				1:       fmt = FMT_FP32;
				default: fmt = FMT_FP16;
			endcase
			run_division(fmt, random_operand(fmt), random_operand(fmt), 1'b0);
		end

		run_edge_cases(FMT_FP16);
		run_edge_cases(FMT_FP32);
		run_edge_cases(FMT_FP64);

		for (i = 0; i < 30; i++) begin
			fmt = random_format();
			run_division(fmt, random_operand(fmt), random_operand(fmt), 1'b1);
		end

		// each flush followed by a normal division
		for (i = 0; i < 15; i++) begin
			run_flush(random_format());
			fmt = random_format();
			run_division(fmt, random_operand(fmt), random_operand(fmt), 1'b0);
		end

		$display("Run complete: %0d value errors, %0d timeouts", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+tests
source/fpdiv_fmt_pkg.sv
source/srt_pkg.sv
source/srt_ctrl.sv
source/srt_prescale.sv
source/srt_r4_qds.sv
source/srt_r4_stage.sv
source/srt_iter_core.sv
source/srt_post.sv
source/fpdiv_frac.sv
tests/tb_fpdiv_frac.sv
